//--- flist.f
hdl/mcd212_pkg.sv
hdl/cpu_address_decoder.sv
hdl/sdram_arbiter.sv
hdl/channel_registers.sv
hdl/mcd212_top.sv
verification/mcd212_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 -f flist.f \
        --top-module mcd212_tb -o mcd212_sim; then
    echo "Build failed"
    exit 1
fi

output=$(./obj_dir/mcd212_sim)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

//--- verification/mcd212_tb.sv
`timescale 1ns/1ps

module mcd212_tb;
    import mcd212_pkg::*;

    localparam int TIMEOUT = 200;
    localparam cpu_addr_t CH1_WORD = CH1_FIRST[22:1];
    localparam cpu_addr_t CH2_WORD = CH2_FIRST[22:1];

    logic        clk;
    logic        reset;
    cpu_addr_t   cpu_address;
    word_t       cpu_din;
    word_t       cpu_dout;
    logic        cpu_uds;
    logic        cpu_lds;
    logic        cpu_write_strobe;
    logic        cpu_bus_ack;
    logic        cs;
    logic        fetch0_as;
    fetch_addr_t fetch0_address;
    logic        fetch0_bus_ack;
    logic        fetch0_burstdata_valid;
    logic        fetch1_as;
    fetch_addr_t fetch1_address;
    logic        fetch1_bus_ack;
    logic        fetch1_burstdata_valid;
    logic        ica0_irq;
    logic        ica1_irq;
    logic        frame_start;
    logic [1:0]  ica_enable;
    logic [1:0]  dca_enable;
    logic        irq;
    sdram_addr_t sdram_addr;
    logic        sdram_rd;
    logic        sdram_wr;
    logic        sdram_word;
    word_t       sdram_din;
    word_t       sdram_dout;
    logic        sdram_busy;
    logic        sdram_burst;
    logic        sdram_refresh;
    logic        sdram_burstdata_valid;

    // Last non-refresh SDRAM command seen by the memory model
    sdram_addr_t last_addr;
    logic        last_wr;
    logic        last_word;
    logic        last_burst;
    word_t       last_din;
    word_t       mem [sdram_addr_t];
    int          line_count;
    int          latency;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    mcd212_top mcd212_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Mirror of the line timer counted from the end of reset
    always @(posedge clk) begin
        if (reset || line_count == LINE_PERIOD - 1) begin
            line_count <= 0;
        end else begin
            line_count <= line_count + 1;
        end
    end

    function automatic word_t fill(input sdram_addr_t a);
        return a[15:0] ^ {a[24:16], a[6:0]} ^ 16'h5a3c;
    endfunction

    function automatic mem_region_e exp_region(input cpu_addr_t a, input logic early);
        logic [22:0] b;
        b = {a, 1'b0};
        if (early) return REGION_ROM;
        if (b <= RAM_LAST) return REGION_RAM;
        if (b >= ROM_FIRST && b <= ROM_LAST) return REGION_ROM;
        if (b <= SYSIO_LAST) return REGION_SYSTEM_IO;
        if (b[22:4] == CH1_FIRST[22:4]) return REGION_CHANNEL1;
        if (b >= CH2_FIRST && b < CH1_FIRST) return REGION_CHANNEL2;
        return REGION_NONE;
    endfunction

    function automatic sdram_addr_t exp_addr(input cpu_addr_t a, input logic rom,
                                             input logic wr, input logic u, input logic l);
        if (rom) return {3'b001, a[21:1], 1'b0};
        return {5'b0, a[21], a[18], a[17:1], wr && u && !l};
    endfunction

    task automatic check(input string msg, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at time %0t: %s, got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("Test %s: failed", name);
        end else begin
            $display("Test %s: ok", name);
        end
        test_errors = errors;
    endtask

    // SDRAM model takes a command while idle and stays busy for 2 to 6 cycles
    initial begin
        sdram_busy = 1'b0;
        sdram_dout = '0;
        sdram_burstdata_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (!reset && !sdram_busy && (sdram_rd || sdram_wr)) begin
                if (sdram_refresh) begin
                    check("refresh read inside line window",
                          32'(line_count >= REFRESH_FIRST && line_count <= REFRESH_LAST), 1);
                end else begin
                    last_addr  = sdram_addr;
                    last_wr    = sdram_wr;
                    last_word  = sdram_word;
                    last_burst = sdram_burst;
                    last_din   = sdram_din;
                    if (sdram_wr) begin
                        mem[sdram_addr] = sdram_din;
                    end
                end
                latency = 2 + int'($urandom() % 5);
                @(posedge clk);
                #2;
                sdram_busy = 1'b1;
                sdram_burstdata_valid = 1'b1;
                sdram_dout = mem.exists(sdram_addr) ? mem[sdram_addr] : fill(sdram_addr);
                repeat (latency - 1) begin
                    @(posedge clk);
                    #2;
                    sdram_burstdata_valid = 1'b0;
                end
                @(posedge clk);
                #2;
                sdram_busy = 1'b0;
                sdram_burstdata_valid = 1'b0;
            end
        end
    end

    task automatic cpu_access(input cpu_addr_t a, input logic wr, input logic u, input logic l,
                              input word_t d, output word_t q, output sdram_addr_t seen);
        int waited;
        waited = 0;
        q = '0;
        seen = '0;
        @(posedge clk);
        #2;
        cpu_address = a;
        cpu_write_strobe = wr;
        cpu_uds = u;
        cpu_lds = l;
        cpu_din = d;
        cs = 1'b1;
        do begin
            @(negedge clk);
            waited++;
        end while (!cpu_bus_ack && waited < TIMEOUT);
        if (cpu_bus_ack) begin
            q = cpu_dout;
            seen = last_addr;
        end else begin
            $display("Timeout: CPU access to %h was never acknowledged", a);
            errors++;
        end
        @(posedge clk);
        #2;
        cs = 1'b0;
        cpu_uds = 1'b0;
        cpu_lds = 1'b0;
        cpu_write_strobe = 1'b0;
    endtask

    task automatic fetch_access(input int n, input fetch_addr_t a, output time ack_time);
        int waited;
        int pulses;
        waited = 0;
        pulses = 0;
        ack_time = 0;
        @(posedge clk);
        #2;
        if (n == 0) begin
            fetch0_address = a;
            fetch0_as = 1'b1;
        end else begin
            fetch1_address = a;
            fetch1_as = 1'b1;
        end
        do begin
            @(negedge clk);
            waited++;
            if (n == 0 ? fetch0_burstdata_valid : fetch1_burstdata_valid) begin
                pulses++;
            end
        end while (!(n == 0 ? fetch0_bus_ack : fetch1_bus_ack) && waited < TIMEOUT);
        if (waited < TIMEOUT || (n == 0 ? fetch0_bus_ack : fetch1_bus_ack)) begin
            ack_time = $time;
            if (n == 0) begin
                check("fetch0 address", 32'(last_addr[19:1]), 32'(a[19:1]));
            end else begin
                check("fetch1 address", 32'(last_addr[19:1]), 32'({1'b1, a[18:1]}));
            end
            check("fetch burst flag", 32'(last_burst), 1);
            check("fetch burst data valid pulses", 32'(pulses), 1);
        end else begin
            $display("Timeout: fetch requester %0d was never acknowledged", n);
            errors++;
        end
        @(posedge clk);
        #2;
        fetch0_as = n == 0 ? 1'b0 : fetch0_as;
        fetch1_as = n == 1 ? 1'b0 : fetch1_as;
    endtask

    task automatic pulse(input int which);
        @(posedge clk);
        #2;
        ica0_irq = which == 0;
        ica1_irq = which == 1;
        frame_start = which == 2;
        @(posedge clk);
        #2;
        ica0_irq = 1'b0;
        ica1_irq = 1'b0;
        frame_start = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        cpu_addr_t   a;
        word_t       q;
        word_t       d;
        sdram_addr_t seen;
        sdram_addr_t ea;
        mem_region_e reg_exp;
        logic [1:0]  d1;
        logic [1:0]  d2;
        logic [1:0]  strobes;
        logic        par;
        time         t0;
        time         t1;
        time         tc;

        r = $urandom(32'hac96);
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        reset = 1'b1;
        cpu_address = '0;
        cpu_din = '0;
        cpu_uds = 1'b0;
        cpu_lds = 1'b0;
        cpu_write_strobe = 1'b0;
        cs = 1'b0;
        fetch0_as = 1'b0;
        fetch0_address = '0;
        fetch1_as = 1'b0;
        fetch1_address = '0;
        ica0_irq = 1'b0;
        ica1_irq = 1'b0;
        frame_start = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        // Four boot reads go to ROM and the fifth to RAM
        for (int i = 0; i < 5; i++) begin
            r = $urandom();
            a = {1'b0, r[20:0]};
            reg_exp = exp_region(a, i < EARLY_ROM_ACCESSES);
            ea = exp_addr(a, reg_exp == REGION_ROM, 1'b0, 1'b1, 1'b1);
            cpu_access(a, 1'b0, 1'b1, 1'b1, '0, q, seen);
            check("boot read address", 32'(seen), 32'(ea));
            check("boot read strobe", 32'(last_wr), 0);
            check("boot read data", 32'(q), 32'(fill(ea)));
        end
        finish_test("early rom");

        for (int i = 0; i < 8; i++) begin
            r = $urandom();
            a = {1'b0, r[20:0]};
            strobes = r[22:21] == 2'b00 ? 2'b11 : r[22:21];
            d = r[31:16];
            ea = exp_addr(a, 1'b0, 1'b1, strobes[1], strobes[0]);
            cpu_access(a, 1'b1, strobes[1], strobes[0], d, q, seen);
            check("RAM write address", 32'(seen), 32'(ea));
            check("RAM write strobe", 32'(last_wr), 1);
            check("RAM write word flag", 32'(last_word), 32'(strobes == 2'b11));
            check("RAM write burst flag", 32'(last_burst), 0);
            check("RAM write data", 32'(last_din), 32'(d));
        end
        finish_test("ram writes");

        r = $urandom();
        d1 = r[1:0];
        d2 = r[3:2];
        cpu_access(CH1_WORD + 1, 1'b1, 1'b1, 1'b1, {6'b0, d1, 8'b0}, q, seen);
        cpu_access(CH2_WORD + 1, 1'b1, 1'b1, 1'b1, {6'b0, d2, 8'b0}, q, seen);
        @(negedge clk);
        check("ica enables", 32'(ica_enable), 32'({d2[1], d1[1]}));
        check("dca enables", 32'(dca_enable), 32'({d2[0], d1[0]}));
        pulse(0);
        cpu_access(CH2_WORD, 1'b0, 1'b1, 1'b0, '0, q, seen);
        check("status 2 after ica0", 32'(q), 32'h0004);
        check("irq with channel 1 enabled", 32'(irq), 1);
        cpu_access(CH1_WORD, 1'b1, 1'b1, 1'b1, 16'h8000, q, seen);
        @(negedge clk);
        check("irq with channel 1 disabled", 32'(irq), 0);
        pulse(1);
        @(negedge clk);
        check("irq from channel 2", 32'(irq), 1);
        cpu_access(CH2_WORD, 1'b0, 1'b0, 1'b1, '0, q, seen);
        check("status 2 before clear", 32'(q), 32'h0006);
        cpu_access(CH2_WORD, 1'b0, 1'b1, 1'b0, '0, q, seen);
        check("status 2 after clear", 32'(q), 32'h0000);
        check("irq after clear", 32'(irq), 0);
        cpu_access(CH1_WORD, 1'b1, 1'b1, 1'b1, 16'h0000, q, seen);
        finish_test("registers and interrupt");

        for (int i = 0; i < 3; i++) begin
            r = $urandom();
            a = {1'b0, r[20:0]};
            ea = exp_addr(a, 1'b0, 1'b0, 1'b1, 1'b1);
            r = $urandom();
            fork
                fetch_access(0, r[21:0], t0);
                fetch_access(1, {r[10:0], r[31:21]}, t1);
                begin
                    cpu_access(a, 1'b0, 1'b1, 1'b1, '0, q, seen);
                    tc = $time;
                end
            join
            check("fetch0 acked before fetch1", 32'(t0 < t1), 1);
            check("CPU served after fetches", 32'(t1 < tc), 1);
            check("CPU read address", 32'(seen), 32'(ea));
            check("CPU read data", 32'(q), 32'(mem.exists(ea) ? mem[ea] : fill(ea)));
        end
        finish_test("arbitration");

        par = 1'b0;
        for (int i = 0; i < 3; i++) begin
            cpu_access(CH1_WORD, 1'b0, 1'b1, 1'b1, '0, q, seen);
            check("status 1 parity", 32'(q), 32'({10'b0, par, 5'b0}));
            pulse(2);
            par = !par;
        end
        finish_test("parity");

        $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- hdl/mcd212_top.sv
`timescale 1ns/1ps

module mcd212_top (
    input  logic                    clk,
    input  logic                    reset,
    input  mcd212_pkg::cpu_addr_t   cpu_address,
    input  mcd212_pkg::word_t       cpu_din,
    output mcd212_pkg::word_t       cpu_dout,
    input  logic                    cpu_uds,
    input  logic                    cpu_lds,
    input  logic                    cpu_write_strobe,
    output logic                    cpu_bus_ack,
    input  logic                    cs,
    input  logic                    fetch0_as,
    input  mcd212_pkg::fetch_addr_t fetch0_address,
    output logic                    fetch0_bus_ack,
    output logic                    fetch0_burstdata_valid,
    input  logic                    fetch1_as,
    input  mcd212_pkg::fetch_addr_t fetch1_address,
    output logic                    fetch1_bus_ack,
    output logic                    fetch1_burstdata_valid,
    input  logic                    ica0_irq,
    input  logic                    ica1_irq,
    input  logic                    frame_start,
    output logic [1:0]              ica_enable,
    output logic [1:0]              dca_enable,
    output logic                    irq,
    output mcd212_pkg::sdram_addr_t sdram_addr,
    output logic                    sdram_rd,
    output logic                    sdram_wr,
    output logic                    sdram_word,
    output mcd212_pkg::word_t       sdram_din,
    input  mcd212_pkg::word_t       sdram_dout,
    input  logic                    sdram_busy,
    output logic                    sdram_burst,
    output logic                    sdram_refresh,
    input  logic                    sdram_burstdata_valid
);
    import mcd212_pkg::*;

    mem_region_e region;
    sdram_addr_t req_address;
    logic        sdram_request;
    logic        req_word;
    logic        req_write;
    logic        req_is_ram;
    logic [3:0]  reg_offset;

    // Low nibble of the byte address selects the channel register
    assign reg_offset = {cpu_address[3:1], 1'b0};

    // Only the CPU writes to SDRAM
    assign sdram_din = cpu_din;

    cpu_address_decoder cpu_address_decoder_inst (
        .clk, .reset, .cpu_address, .cpu_uds, .cpu_lds, .cpu_write_strobe, .cs,
        .cpu_bus_ack, .region, .sdram_request, .req_address, .req_word, .req_write,
        .req_is_ram
    );

    sdram_arbiter sdram_arbiter_inst (
        .clk, .reset, .sdram_request, .req_address, .req_word, .req_write, .req_is_ram,
        .fetch0_as, .fetch0_address, .fetch1_as, .fetch1_address,
        .sdram_busy, .sdram_burstdata_valid, .cpu_bus_ack,
        .fetch0_bus_ack, .fetch0_burstdata_valid, .fetch1_bus_ack, .fetch1_burstdata_valid,
        .sdram_addr, .sdram_rd, .sdram_wr, .sdram_word, .sdram_burst, .sdram_refresh
    );

    channel_registers channel_registers_inst (
        .clk, .reset, .region, .reg_offset, .cpu_uds, .cpu_lds, .cpu_write_strobe,
        .cpu_din, .sdram_dout, .ica0_irq, .ica1_irq, .frame_start,
        .cpu_dout, .irq, .ica_enable, .dca_enable
    );

endmodule

//--- hdl/channel_registers.sv
`timescale 1ns/1ps

module channel_registers (
    input  logic                    clk,
    input  logic                    reset,
    input  mcd212_pkg::mem_region_e region,
    input  logic [3:0]              reg_offset,
    input  logic                    cpu_uds,
    input  logic                    cpu_lds,
    input  logic                    cpu_write_strobe,
    input  mcd212_pkg::word_t       cpu_din,
    input  mcd212_pkg::word_t       sdram_dout,
    input  logic                    ica0_irq,
    input  logic                    ica1_irq,
    input  logic                    frame_start,
    output mcd212_pkg::word_t       cpu_dout,
    output logic                    irq,
    output logic [1:0]              ica_enable,
    output logic [1:0]              dca_enable
);
    import mcd212_pkg::*;

    // IC in bit 9 and DC in bit 8 of both command registers
    logic [9:8] dcr1;
    logic [9:8] dcr2;
    logic       di1;
    logic       di2;
    logic       it1;
    logic       it2;
    logic       parity;
    logic       ch1_write;
    logic       ch2_write;
    logic       status2_clear;
    word_t      status1;
    word_t      status2;

    assign ch1_write = (cpu_uds || cpu_lds) && cpu_write_strobe && region == REGION_CHANNEL1;
    assign ch2_write = (cpu_uds || cpu_lds) && cpu_write_strobe && region == REGION_CHANNEL2;

    // Reading status 2 acknowledges both interrupts
    assign status2_clear = cpu_lds && !cpu_write_strobe && region == REGION_CHANNEL2 &&
                           reg_offset == REG_CONTROL;

    always_ff @(posedge clk) begin
        if (reset) begin
            dcr1   <= '0;
            dcr2   <= '0;
            di1    <= 1'b0;
            di2    <= 1'b0;
            it1    <= 1'b0;
            it2    <= 1'b0;
            parity <= 1'b0;
        end else begin
            if (ch1_write && reg_offset == REG_COMMAND) begin
                dcr1 <= cpu_din[9:8];
            end
            if (ch1_write && reg_offset == REG_CONTROL && cpu_uds) begin
                di1 <= cpu_din[15];
            end
            if (ch2_write && reg_offset == REG_COMMAND) begin
                dcr2 <= cpu_din[9:8];
            end
            if (ch2_write && reg_offset == REG_CONTROL) begin
                di2 <= cpu_din[15];
            end

            if (status2_clear) begin
                it1 <= 1'b0;
                it2 <= 1'b0;
            end
            // A new request wins over a clear in the same cycle
            if (ica0_irq) begin
                it1 <= 1'b1;
            end
            if (ica1_irq) begin
                it2 <= 1'b1;
            end

            if (frame_start) begin
                parity <= !parity;
            end
        end
    end

    assign ica_enable = {dcr2[9], dcr1[9]};
    assign dca_enable = {dcr2[8], dcr1[8]};

    assign irq = (it1 && !di1) || (it2 && !di2);

    assign status1 = {10'b0, parity, 5'b0};
    assign status2 = {13'b0, it1, it2, 1'b0};

    always_comb begin
        case (region)
            REGION_RAM, REGION_ROM: cpu_dout = sdram_dout;
            REGION_CHANNEL1:        cpu_dout = (reg_offset == REG_CONTROL) ? status1 : '0;
            REGION_CHANNEL2:        cpu_dout = (reg_offset == REG_CONTROL) ? status2 : '0;
            default:                cpu_dout = '0;
        endcase
    end

    // Channel 1 registers only take full-word writes
    a_ch1_word_write: assert property (@(posedge clk) disable iff (reset)
        ch1_write |-> cpu_uds && cpu_lds);

endmodule

//--- hdl/sdram_arbiter.sv
`timescale 1ns/1ps

module sdram_arbiter (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sdram_request,
    input  mcd212_pkg::sdram_addr_t req_address,
    input  logic                    req_word,
    input  logic                    req_write,
    input  logic                    req_is_ram,
    input  logic                    fetch0_as,
    input  mcd212_pkg::fetch_addr_t fetch0_address,
    input  logic                    fetch1_as,
    input  mcd212_pkg::fetch_addr_t fetch1_address,
    input  logic                    sdram_busy,
    input  logic                    sdram_burstdata_valid,
    output logic                    cpu_bus_ack,
    output logic                    fetch0_bus_ack,
    output logic                    fetch0_burstdata_valid,
    output logic                    fetch1_bus_ack,
    output logic                    fetch1_burstdata_valid,
    output mcd212_pkg::sdram_addr_t sdram_addr,
    output logic                    sdram_rd,
    output logic                    sdram_wr,
    output logic                    sdram_word,
    output logic                    sdram_burst,
    output logic                    sdram_refresh
);
    import mcd212_pkg::*;

    logic [LINE_TIMER_W-1:0] line_timer;
    logic                    refresh_request;
    logic                    sdram_busy_q;
    logic                    cmd_allowed;
    logic                    access_done;
    arbit_target_e           owner;
    arbit_target_e           owner_q;
    arbit_target_e           owner_next;

    // Stands in for the horizontal position of the video timing
    always_ff @(posedge clk) begin
        if (reset) begin
            line_timer <= '0;
        end else if (line_timer == LINE_TIMER_W'(LINE_PERIOD - 1)) begin
            line_timer <= '0;
        end else begin
            line_timer <= line_timer + 1'b1;
        end
    end

    assign refresh_request = line_timer >= LINE_TIMER_W'(REFRESH_FIRST) &&
                             line_timer <= LINE_TIMER_W'(REFRESH_LAST);

    always_comb begin
        owner_next = CPU;
        if (refresh_request) begin
            owner_next = REFRESH;
        end else if (fetch0_as) begin
            owner_next = FETCH0;
        end else if (fetch1_as) begin
            owner_next = FETCH1;
        end
    end

    // Ownership may only move between accesses
    assign owner = sdram_busy ? owner_q : owner_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            sdram_busy_q <= 1'b0;
            owner_q      <= CPU;
        end else begin
            sdram_busy_q <= sdram_busy;
            owner_q      <= owner;
        end
    end

    // Busy needs one cycle to show up after a command
    assign cmd_allowed = !sdram_busy && !sdram_busy_q;
    assign access_done = !sdram_busy && sdram_busy_q;

    always_comb begin
        sdram_addr    = '0;
        sdram_rd      = 1'b0;
        sdram_wr      = 1'b0;
        sdram_word    = 1'b0;
        sdram_burst   = 1'b0;
        sdram_refresh = 1'b0;
        case (owner)
            REFRESH: begin
                // Dummy reads keep the controller's auto refresh going
                sdram_refresh = 1'b1;
                sdram_rd      = !sdram_busy;
            end
            FETCH0: begin
                sdram_word = 1'b1;
                if (fetch0_as) begin
                    sdram_addr[19:1] = fetch0_address[19:1];
                    sdram_rd         = cmd_allowed;
                    sdram_burst      = 1'b1;
                end
            end
            FETCH1: begin
                sdram_word = 1'b1;
                if (fetch1_as) begin
                    // Channel 1 fetches from the upper half bank
                    sdram_addr[19]   = 1'b1;
                    sdram_addr[18:1] = fetch1_address[18:1];
                    sdram_rd         = cmd_allowed;
                    sdram_burst      = 1'b1;
                end
            end
            default: begin
                if (sdram_request) begin
                    sdram_addr = req_address;
                    sdram_word = req_word;
                    sdram_rd   = !(req_is_ram && req_write) && cmd_allowed;
                    sdram_wr   = req_is_ram && req_write && cmd_allowed;
                end
            end
        endcase
    end

    always_comb begin
        // Non-SDRAM CPU cycles complete at once
        cpu_bus_ack            = !sdram_request;
        fetch0_bus_ack         = 1'b0;
        fetch0_burstdata_valid = 1'b0;
        fetch1_bus_ack         = 1'b0;
        fetch1_burstdata_valid = 1'b0;
        case (owner_q)
            FETCH0: begin
                if (fetch0_as) begin
                    fetch0_bus_ack         = access_done;
                    fetch0_burstdata_valid = sdram_burstdata_valid;
                end
            end
            FETCH1: begin
                if (fetch1_as) begin
                    fetch1_bus_ack         = access_done;
                    fetch1_burstdata_valid = sdram_burstdata_valid;
                end
            end
            CPU: begin
                if (sdram_request) begin
                    cpu_bus_ack = access_done;
                end
            end
            default: begin
            end
        endcase
    end

    // The held owner keeps its address on the port until busy falls
    a_owner_held: assert property (@(posedge clk) disable iff (reset)
        sdram_busy |-> $stable(sdram_addr));

endmodule

//--- hdl/cpu_address_decoder.sv
`timescale 1ns/1ps

module cpu_address_decoder (
    input  logic                      clk,
    input  logic                      reset,
    input  mcd212_pkg::cpu_addr_t     cpu_address,
    input  logic                      cpu_uds,
    input  logic                      cpu_lds,
    input  logic                      cpu_write_strobe,
    input  logic                      cs,
    input  logic                      cpu_bus_ack,
    output mcd212_pkg::mem_region_e   region,
    output logic                      sdram_request,
    output mcd212_pkg::sdram_addr_t   req_address,
    output logic                      req_word,
    output logic                      req_write,
    output logic                      req_is_ram
);
    import mcd212_pkg::*;

    logic [2:0]  early_rom_count;
    logic        early_rom;
    logic [22:0] byte_addr;
    logic        upper_only_write;

    assign byte_addr = {cpu_address, 1'b0};
    assign early_rom = early_rom_count < 3'(EARLY_ROM_ACCESSES);

    // Boot vectors come from ROM until enough upper-byte accesses completed
    always_ff @(posedge clk) begin
        if (reset) begin
            early_rom_count <= '0;
        end else if (cs && cpu_uds && early_rom && cpu_bus_ack) begin
            early_rom_count <= early_rom_count + 3'd1;
        end
    end

    always_comb begin
        region = REGION_NONE;
        if (cs) begin
            if (early_rom) begin
                region = REGION_ROM;
            end else if (byte_addr <= RAM_LAST) begin
                region = REGION_RAM;
            end else if (byte_addr >= ROM_FIRST && byte_addr <= ROM_LAST) begin
                region = REGION_ROM;
            end else if (byte_addr <= SYSIO_LAST) begin
                region = REGION_SYSTEM_IO;
            end else if (byte_addr >= CH2_FIRST && byte_addr < CH1_FIRST) begin
                region = REGION_CHANNEL2;
            end else if (byte_addr[22:4] == CH1_FIRST[22:4]) begin
                region = REGION_CHANNEL1;
            end
        end
    end

    assign req_is_ram    = region == REGION_RAM;
    assign sdram_request = (req_is_ram || region == REGION_ROM) && (cpu_uds || cpu_lds);
    assign req_write     = cpu_write_strobe;

    // Odd byte lane is selected by address bit 0
    assign upper_only_write = cpu_write_strobe && cpu_uds && !cpu_lds;

    always_comb begin
        if (req_is_ram) begin
            // Bank select moves to bit 18, A21 lands on bit 19
            req_address = {5'b0, cpu_address[21], cpu_address[18], cpu_address[17:1],
                           upper_only_write};
            req_word    = (cpu_uds && cpu_lds) || !cpu_write_strobe;
        end else begin
            req_address = {ROM_SDRAM_PREFIX, cpu_address[21:1], 1'b0};
            req_word    = 1'b1;
        end
    end

endmodule

//--- hdl/mcd212_pkg.sv
package mcd212_pkg;

    typedef logic [15:0] word_t;
    typedef logic [22:1] cpu_addr_t;
    typedef logic [24:0] sdram_addr_t;
    typedef logic [21:0] fetch_addr_t;

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_RAM,
        REGION_ROM,
        REGION_SYSTEM_IO,
        REGION_CHANNEL1,
        REGION_CHANNEL2
    } mem_region_e;

    // SDRAM owners, highest priority first
    typedef enum logic [1:0] {
        REFRESH,
        FETCH0,
        FETCH1,
        CPU
    } arbit_target_e;

    // CPU memory map, byte addresses
    localparam logic [22:0] RAM_LAST   = 23'h3fffff;
    localparam logic [22:0] ROM_FIRST  = 23'h400000;
    localparam logic [22:0] ROM_LAST   = 23'h4ffbff;
    localparam logic [22:0] SYSIO_LAST = 23'h4fffdf;
    localparam logic [22:0] CH2_FIRST  = 23'h4fffe0;
    localparam logic [22:0] CH1_FIRST  = 23'h4ffff0;

    // Upper-byte accesses after reset that still see ROM at address 0
    localparam int EARLY_ROM_ACCESSES = 4;
    localparam logic [2:0] ROM_SDRAM_PREFIX = 3'b001;

    // Offsets inside a channel register window
    localparam logic [3:0] REG_CONTROL = 4'h0;
    localparam logic [3:0] REG_COMMAND = 4'h2;

    // Line timer, refresh window 21..79 of a full line scaled down
    localparam int LINE_PERIOD   = 64;
    localparam int LINE_TIMER_W  = $clog2(LINE_PERIOD);
    localparam int REFRESH_FIRST = 5;
    localparam int REFRESH_LAST  = 12;

endpackage
